// ==== rtl/tt_pkg.sv ====
package tt_pkg;

  // Width of ui_in, uo_out and each of the three uio words
  localparam int PIN_W = 8;

  // Populated tile addresses start at zero and are contiguous
  localparam int NUM_TILES = 3;

  localparam int TILE_COUNTER = 0;
  localparam int TILE_ACCUM   = 1;
  localparam int TILE_SHIFT   = 2;

endpackage

// ==== rtl/tile_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pin bundle of one user tile as seen through the shared mux
interface tile_if;

  logic                     clk;
  logic                     rst_n;
  logic                     ena;
  logic [tt_pkg::PIN_W-1:0] ui_in;
  logic [tt_pkg::PIN_W-1:0] uio_in;
  logic [tt_pkg::PIN_W-1:0] uo_out;
  logic [tt_pkg::PIN_W-1:0] uio_out;
  logic [tt_pkg::PIN_W-1:0] uio_oe;

  modport mux (
    output clk,
    output rst_n,
    output ena,
    output ui_in,
    output uio_in,
    input  uo_out,
    input  uio_out,
    input  uio_oe
  );

  modport tile (
    input  clk,
    input  rst_n,
    input  ena,
    input  ui_in,
    input  uio_in,
    output uo_out,
    output uio_out,
    output uio_oe
  );

endinterface

`default_nettype wire

// ==== rtl/sel_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sel_counter #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ctrl_sel_rst_n,
  input  logic              ctrl_sel_inc,
  output logic [ADDR_W-1:0] addr
);

  logic inc_q;
  logic inc_rise;

  // Only a low sample followed by a high sample counts as a step
  assign inc_rise = ctrl_sel_inc & ~inc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // A level held high through reset is not an edge
      inc_q <= 1'b1;
    end else begin
      inc_q <= ctrl_sel_inc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (!ctrl_sel_rst_n) begin
      addr <= '0;
    end else if (inc_rise) begin
      // Wraps naturally at the top of the address range
      addr <= addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tile_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_mux #(
  parameter int ADDR_W = 5
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ctrl_ena,
  input  logic [ADDR_W-1:0]        addr,
  input  logic [tt_pkg::PIN_W-1:0] ui_in,
  input  logic [tt_pkg::PIN_W-1:0] uio_in,
  output logic [tt_pkg::PIN_W-1:0] uo_out,
  output logic [tt_pkg::PIN_W-1:0] uio_out,
  output logic [tt_pkg::PIN_W-1:0] uio_oe,
  tile_if.mux                      tiles [tt_pkg::NUM_TILES]
);

  logic [tt_pkg::NUM_TILES-1:0] sel;
  logic [tt_pkg::NUM_TILES-1:0] clk_en;

  logic [tt_pkg::PIN_W-1:0] tile_uo   [tt_pkg::NUM_TILES];
  logic [tt_pkg::PIN_W-1:0] tile_uio  [tt_pkg::NUM_TILES];
  logic [tt_pkg::PIN_W-1:0] tile_oe   [tt_pkg::NUM_TILES];

  // Select enable is only allowed to change while clk is low, so a tile
  // never sees a partial clock pulse when the address moves
  always_latch begin
    if (!clk) begin
      clk_en = sel;
    end
  end

  for (genvar i = 0; i < tt_pkg::NUM_TILES; i++) begin : g_tile
    // Compare at full integer width so small ADDR_W values cannot alias
    assign sel[i] = (int'(addr) == i);

    assign tiles[i].clk    = clk & clk_en[i];
    // Reset reaches every tile so no tile starts up in an unknown state
    assign tiles[i].rst_n  = rst_n;
    assign tiles[i].ena    = ctrl_ena & sel[i];
    assign tiles[i].ui_in  = sel[i] ? ui_in  : '0;
    assign tiles[i].uio_in = sel[i] ? uio_in : '0;

    assign tile_uo[i]  = tiles[i].uo_out;
    assign tile_uio[i] = tiles[i].uio_out;
    assign tile_oe[i]  = tiles[i].uio_oe;
  end

  // Unpopulated addresses leave all three words at zero
  always_comb begin
    uo_out  = '0;
    uio_out = '0;
    uio_oe  = '0;
    if (ctrl_ena) begin
      for (int i = 0; i < tt_pkg::NUM_TILES; i++) begin
        if (sel[i]) begin
          uo_out  = tile_uo[i];
          uio_out = tile_uio[i];
          uio_oe  = tile_oe[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tile_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// User tile 0, a free-running counter on the dedicated outputs
module tile_counter (
  tile_if.tile bus
);

  logic [tt_pkg::PIN_W-1:0] count;

  always_ff @(posedge bus.clk or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      count <= '0;
    end else if (bus.ena) begin
      count <= count + 1'b1;
    end
  end

  assign bus.uo_out = count;

  // The bidirectional pins stay inputs for this tile
  assign bus.uio_out = '0;
  assign bus.uio_oe  = '0;

endmodule

`default_nettype wire

// ==== rtl/tile_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

// User tile 1, adds ui_in into a running sum when uio_in[0] is high
module tile_accum (
  tile_if.tile bus
);

  logic [tt_pkg::PIN_W-1:0] acc;
  logic                     add_en;

  assign add_en = bus.ena & bus.uio_in[0];

  always_ff @(posedge bus.clk or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      acc <= '0;
    end else if (add_en) begin
      // Carry out of the top bit is dropped
      acc <= acc + bus.ui_in;
    end
  end

  assign bus.uo_out  = acc;
  assign bus.uio_out = '0;
  assign bus.uio_oe  = '0;

endmodule

`default_nettype wire

// ==== rtl/tile_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

// User tile 2, serial shift register with the uio group as outputs
module tile_shift (
  tile_if.tile bus
);

  logic [tt_pkg::PIN_W-1:0] shreg;

  always_ff @(posedge bus.clk or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      shreg <= '0;
    end else if (bus.ena) begin
      // New bit enters at the bottom, the top bit falls off
      shreg <= {shreg[tt_pkg::PIN_W-2:0], bus.ui_in[0]};
    end
  end

  assign bus.uo_out = shreg;

  // Inverted copy of ui_in makes the bidirectional pads easy to probe
  assign bus.uio_out = ~bus.ui_in;
  assign bus.uio_oe  = '1;

endmodule

`default_nettype wire

// ==== rtl/tt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tt_top #(
  parameter int ADDR_W = 5
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ctrl_sel_rst_n,
  input  logic                     ctrl_sel_inc,
  input  logic                     ctrl_ena,
  input  logic                     loopback_in,
  input  logic [tt_pkg::PIN_W-1:0] ui_in,
  input  logic [tt_pkg::PIN_W-1:0] uio_in,
  output logic [tt_pkg::PIN_W-1:0] uo_out,
  output logic [tt_pkg::PIN_W-1:0] uio_out,
  output logic [tt_pkg::PIN_W-1:0] uio_oe,
  output logic                     loopback_out
);

  logic [ADDR_W-1:0] addr;

  tile_if tiles [tt_pkg::NUM_TILES] ();

  // Pad test path, kept free of any clock or reset
  assign loopback_out = loopback_in;

  sel_counter #(
    .ADDR_W (ADDR_W)
  ) counter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_sel_rst_n (ctrl_sel_rst_n),
    .ctrl_sel_inc   (ctrl_sel_inc),
    .addr           (addr)
  );

  tile_mux #(
    .ADDR_W (ADDR_W)
  ) mux_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl_ena (ctrl_ena),
    .addr     (addr),
    .ui_in    (ui_in),
    .uio_in   (uio_in),
    .uo_out   (uo_out),
    .uio_out  (uio_out),
    .uio_oe   (uio_oe),
    .tiles    (tiles)
  );

  tile_counter tile_counter_i (
    .bus (tiles[tt_pkg::TILE_COUNTER])
  );

  tile_accum tile_accum_i (
    .bus (tiles[tt_pkg::TILE_ACCUM])
  );

  tile_shift tile_shift_i (
    .bus (tiles[tt_pkg::TILE_SHIFT])
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

// Free-running testbench clock, starts low
module tb_clock #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== verif/tt_top_checker.sv ====
`timescale 1ns/1ps

module tt_top_checker #(
  parameter int ADDR_W = 5
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     ctrl_sel_rst_n,
  input logic                     ctrl_sel_inc,
  input logic                     ctrl_ena,
  input logic                     loopback_in,
  input logic [tt_pkg::PIN_W-1:0] ui_in,
  input logic [tt_pkg::PIN_W-1:0] uio_in,
  input logic [tt_pkg::PIN_W-1:0] uo_out,
  input logic [tt_pkg::PIN_W-1:0] uio_out,
  input logic [tt_pkg::PIN_W-1:0] uio_oe,
  input logic                     loopback_out
);

  localparam int W = tt_pkg::PIN_W;

  int error_count = 0;
  int check_count = 0;

  logic              inc_prev;
  logic [ADDR_W-1:0] addr_m;
  logic [W-1:0]      count_m;
  logic [W-1:0]      acc_m;
  logic [W-1:0]      shreg_m;
  logic [W-1:0]      exp_uo;
  logic [W-1:0]      exp_uio;
  logic [W-1:0]      exp_oe;

  // Reference models of the selection address and the three tiles.
  // A tile advances only at an edge where it is addressed and enabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // No low sample exists before the first edge, so no step yet
      inc_prev <= 1'b1;
      addr_m   <= '0;
      count_m  <= '0;
      acc_m    <= '0;
      shreg_m  <= '0;
    end else begin
      inc_prev <= ctrl_sel_inc;
      if (!ctrl_sel_rst_n) begin
        addr_m <= '0;
      end else if (ctrl_sel_inc && !inc_prev) begin
        addr_m <= addr_m + 1'b1;
      end
      if (ctrl_ena && int'(addr_m) == tt_pkg::TILE_COUNTER) begin
        count_m <= count_m + 1'b1;
      end
      if (ctrl_ena && int'(addr_m) == tt_pkg::TILE_ACCUM && uio_in[0]) begin
        acc_m <= acc_m + ui_in;
      end
      if (ctrl_ena && int'(addr_m) == tt_pkg::TILE_SHIFT) begin
        shreg_m <= {shreg_m[W-2:0], ui_in[0]};
      end
    end
  end

  always_comb begin
    exp_uo  = '0;
    exp_uio = '0;
    exp_oe  = '0;
    if (ctrl_ena) begin
      if (int'(addr_m) == tt_pkg::TILE_COUNTER) begin
        exp_uo = count_m;
      end else if (int'(addr_m) == tt_pkg::TILE_ACCUM) begin
        exp_uo = acc_m;
      end else if (int'(addr_m) == tt_pkg::TILE_SHIFT) begin
        exp_uo  = shreg_m;
        exp_uio = ~ui_in;
        exp_oe  = '1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      check_count <= check_count + 1;
    end
  end

  // The pad path is checked through reset as well
  a_loopback: assert property (@(posedge clk) loopback_out == loopback_in)
    else begin
      error_count++;
      $error("ERROR at %0t: loopback_out expected %b, got %b",
             $time, $sampled(loopback_in), $sampled(loopback_out));
    end

  a_uo_out: assert property (@(posedge clk) disable iff (!rst_n) uo_out == exp_uo)
    else begin
      error_count++;
      $error("ERROR at %0t: uo_out expected %h, got %h",
             $time, $sampled(exp_uo), $sampled(uo_out));
    end

  a_uio_out: assert property (@(posedge clk) disable iff (!rst_n) uio_out == exp_uio)
    else begin
      error_count++;
      $error("ERROR at %0t: uio_out expected %h, got %h",
             $time, $sampled(exp_uio), $sampled(uio_out));
    end

  a_uio_oe: assert property (@(posedge clk) disable iff (!rst_n) uio_oe == exp_oe)
    else begin
      error_count++;
      $error("ERROR at %0t: uio_oe expected %h, got %h",
             $time, $sampled(exp_oe), $sampled(uio_oe));
    end

endmodule

bind tt_top tt_top_checker #(.ADDR_W(ADDR_W)) checker_i (.*);

// ==== verif/tb_tt_top.sv ====
`timescale 1ns/1ps

module tb_tt_top;

  localparam int ADDR_W       = 5;
  localparam int W            = tt_pkg::PIN_W;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 24;
  localparam int OFF_CYCLES   = 6;
  // Every address once, then one more selection that wraps back to tile 0
  localparam int NUM_SEL      = 2**ADDR_W + 1;
  // Selecting address n takes one clear cycle plus two cycles per increment pulse
  localparam int SEL_CYCLES   = NUM_SEL * NUM_SEL;
  localparam int TOTAL_CYCLES = RESET_CYCLES + SEL_CYCLES
                              + NUM_SEL * (2 * RUN_CYCLES + OFF_CYCLES) + 1;
  localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 200;

  logic         clk;
  logic         rst_n;
  logic         ctrl_sel_rst_n;
  logic         ctrl_sel_inc;
  logic         ctrl_ena;
  logic         loopback_in;
  logic [W-1:0] ui_in;
  logic [W-1:0] uio_in;
  logic [W-1:0] uo_out;
  logic [W-1:0] uio_out;
  logic [W-1:0] uio_oe;
  logic         loopback_out;

  integer seed = 86162;
  int     errors;

  tb_clock #(
    .PERIOD_NS (10.0)
  ) clock_i (
    .clk (clk)
  );

  tt_top #(
    .ADDR_W (ADDR_W)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_sel_rst_n (ctrl_sel_rst_n),
    .ctrl_sel_inc   (ctrl_sel_inc),
    .ctrl_ena       (ctrl_ena),
    .loopback_in    (loopback_in),
    .ui_in          (ui_in),
    .uio_in         (uio_in),
    .uo_out         (uo_out),
    .uio_out        (uio_out),
    .uio_oe         (uio_oe),
    .loopback_out   (loopback_out)
  );

  // Waits for the next edge, then puts fresh random data on the pins
  task automatic advance_cycle();
    @(posedge clk);
    #1;
    ui_in       = W'($random(seed));
    uio_in      = W'($random(seed));
    loopback_in = 1'($random(seed));
  endtask

  task automatic run_cycles(input int n, input logic ena);
    ctrl_ena = ena;
    repeat (n) advance_cycle();
  endtask

  // Clear the address, then step it up with n rising pulses
  task automatic select_tile(input int n);
    ctrl_sel_rst_n = 1'b0;
    advance_cycle();
    ctrl_sel_rst_n = 1'b1;
    for (int i = 0; i < n; i++) begin
      ctrl_sel_inc = 1'b1;
      advance_cycle();
      ctrl_sel_inc = 1'b0;
      advance_cycle();
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    ctrl_sel_rst_n = 1'b1;
    ctrl_sel_inc   = 1'b0;
    ctrl_ena       = 1'b0;
    loopback_in    = 1'b0;
    ui_in          = '0;
    uio_in         = '0;
    // Loopback keeps toggling while the rest of the design is held in reset
    repeat (RESET_CYCLES) advance_cycle();
    rst_n = 1'b1;

    for (int n = 0; n < NUM_SEL; n++) begin
      // Odd passes keep the enable high while the address moves
      ctrl_ena = n[0];
      select_tile(n);
      run_cycles(RUN_CYCLES, 1'b1);
      run_cycles(OFF_CYCLES, 1'b0);
      run_cycles(RUN_CYCLES, 1'b1);
    end
    @(posedge clk);
    #1;

    errors = UUT.checker_i.error_count;
    $display("Run complete: %0d assertion errors in %0d checked cycles",
             errors, UUT.checker_i.check_count);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the test sequence did not finish within %0d clock cycles",
             TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/tt_pkg.sv
rtl/tile_if.sv
rtl/sel_counter.sv
rtl/tile_mux.sv
rtl/tile_counter.sv
rtl/tile_accum.sv
rtl/tile_shift.sv
rtl/tt_top.sv
verif/tb_clock.sv
verif/tt_top_checker.sv
verif/tb_tt_top.sv
